//--- bgFetcher.sv
`timescale 1ns/1ps
`default_nettype none

module bgFetcher
   import ppuPkg::*;
(
   input  logic                     clock,
   input  logic                     rstN,
   input  lineStatus                status,
   input  logic [7:0]               vramRdata,
   output logic [vramAddrWidth-1:0] vramAddr,
   output logic [2*screenWidth-1:0] indexLine,
   output logic                     lineReady
);

   localparam logic [4:0] tileColumns = 5'(screenWidth / 8);
   localparam logic [4:0] fetchSlots  = tileColumns + 5'd1;    // Last slot idles

   logic [2:0] step;
   logic [4:0] column;
   logic [7:0] tileNum;
   logic [7:0] lowPlane;
   logic       fetching;

   assign fetching = status.mode == modeTransfer && column != fetchSlots;

   // Address for step n, data back in step n+1
   always_comb begin
      case (step)
         3'd0, 3'd1: vramAddr = tileMapBase + 13'({status.ly[7:3], column});
         3'd2, 3'd3: vramAddr = {1'b0, tileNum, status.ly[2:0], 1'b0};
         default:    vramAddr = {1'b0, tileNum, status.ly[2:0], 1'b1};
      endcase
   end

   always_ff @(posedge clock or negedge rstN) begin
      if (!rstN) begin
         step      <= 3'd0;
         column    <= 5'd0;
         lineReady <= 1'b0;
      end else begin
         lineReady <= fetching && column == fetchSlots - 5'd1 && step == 3'd5;
         if (status.mode != modeTransfer) begin
            step   <= 3'd0;    // Armed for next mode 3
            column <= 5'd0;
         end else if (fetching) begin
            if (step == 3'd5) begin
               step   <= 3'd0;
               column <= column + 5'd1;
            end else begin
               step <= step + 3'd1;
            end
         end
      end
   end

   always_ff @(posedge clock) begin
      if (fetching && step == 3'd1)
         tileNum <= vramRdata;
      if (fetching && step == 3'd3)
         lowPlane <= vramRdata;
      if (fetching && step == 3'd5 && column < tileColumns) begin
         for (int i = 0; i < 8; i++) begin
            // Bit 7 is the leftmost pixel
            indexLine[{column, 3'(i), 1'b0} +: 2] <= {vramRdata[7 - i], lowPlane[7 - i]};
         end
      end
   end

endmodule

`default_nettype wire

//--- filelist.f
ppuPkg.sv
wbRegisterFile.sv
videoRam.sv
lineTiming.sv
bgFetcher.sv
pixelStreamer.sv
ppuTop.sv
tbPpu.sv

//--- lineTiming.sv
`timescale 1ns/1ps
`default_nettype none

module lineTiming
   import ppuPkg::*;
#(
   parameter int unsigned linesVisible = 144,
   parameter int unsigned linesTotal   = 154
) (
   input  logic       clock,
   input  logic       rstN,
   input  logic       lcdEnable,
   input  logic [7:0] lyc,
   output lineStatus  status,
   output logic       irq
);

   logic [8:0] dotCount;
   logic [7:0] lyCount;
   logic       visible;
   ppuMode     mode;

   always_ff @(posedge clock or negedge rstN) begin
      if (!rstN) begin
         dotCount <= 9'd0;
         lyCount  <= 8'd0;
      end else if (!lcdEnable) begin
         dotCount <= 9'd0;
         lyCount  <= 8'd0;
      end else if (dotCount == lineDots - 9'd1) begin
         dotCount <= 9'd0;
         lyCount  <= (lyCount == 8'(linesTotal - 1)) ? 8'd0 : lyCount + 8'd1;
      end else begin
         dotCount <= dotCount + 9'd1;
      end
   end

   assign visible = lyCount < 8'(linesVisible);

   always_comb begin
      if (!lcdEnable)
         mode = modeHBlank;
      else if (!visible)
         mode = modeVBlank;
      else if (dotCount < oamDots)
         mode = modeOamSearch;
      else if (dotCount < transferEndDot)
         mode = modeTransfer;
      else
         mode = modeHBlank;
   end

   assign status.ly          = lyCount;
   assign status.mode        = mode;
   assign status.dot         = dotCount;
   assign status.coincidence = lyCount == lyc;

   assign irq = mode == modeVBlank;    // Level for whole vblank

endmodule

`default_nettype wire

//--- pixelStreamer.sv
`timescale 1ns/1ps
`default_nettype none

module pixelStreamer
   import ppuPkg::*;
(
   input  logic                     clock,
   input  logic                     rstN,
   input  lineStatus                status,
   input  logic [7:0]               bgp,
   input  logic [2*screenWidth-1:0] indexLine,
   input  logic                     lineReady,
   output pixelOut                  pixel
);

   localparam logic [7:0] lastPixel = 8'(screenWidth - 1);

   logic                     readyFlag;
   logic                     streaming;
   logic [7:0]               pixelCount;
   logic [7:0]               lineNum;
   logic [2*screenWidth-1:0] lineBuf;
   logic [1:0]               colourIndex;
   logic                     hblankStart;
   logic                     takeLine;

   // Only reached on a visible line with the LCD on
   assign hblankStart = status.mode == modeHBlank && status.dot == transferEndDot;
   assign takeLine    = hblankStart && readyFlag;

   always_ff @(posedge clock or negedge rstN) begin
      if (!rstN) begin
         readyFlag  <= 1'b0;
         streaming  <= 1'b0;
         pixelCount <= 8'd0;
         lineNum    <= 8'd0;
      end else if (takeLine) begin
         readyFlag  <= 1'b0;
         streaming  <= 1'b1;
         pixelCount <= 8'd0;
         lineNum    <= status.ly;
      end else begin
         if (lineReady)
            readyFlag <= 1'b1;
         if (streaming) begin
            if (pixelCount == lastPixel)
               streaming <= 1'b0;
            pixelCount <= pixelCount + 8'd1;
         end
      end
   end

   always_ff @(posedge clock) begin
      if (takeLine)
         lineBuf <= indexLine;
   end

   assign colourIndex = lineBuf[{pixelCount, 1'b0} +: 2];

   assign pixel.valid = streaming;
   assign pixel.shade = bgp[{colourIndex, 1'b0} +: 2];    // BGP lookup
   assign pixel.line  = lineNum;

endmodule

`default_nettype wire

//--- ppuPkg.sv
`default_nettype none

package ppuPkg;

   localparam logic [8:0] lineDots       = 9'd456;
   localparam logic [8:0] oamDots        = 9'd80;
   localparam logic [8:0] transferEndDot = 9'd252;

   localparam int unsigned screenWidth   = 160;
   localparam int unsigned vramAddrWidth = 13;
   localparam logic [12:0] tileMapBase   = 13'h1800;

   localparam logic [15:0] vramBusBase = 16'h8000;
   localparam logic [15:0] lcdcAddr    = 16'hFF40;
   localparam logic [15:0] statAddr    = 16'hFF41;
   localparam logic [15:0] lyAddr      = 16'hFF44;
   localparam logic [15:0] lycAddr     = 16'hFF45;
   localparam logic [15:0] bgpAddr     = 16'hFF47;

   typedef enum logic [1:0] {
      modeHBlank    = 2'd0,
      modeVBlank    = 2'd1,
      modeOamSearch = 2'd2,
      modeTransfer  = 2'd3
   } ppuMode;

   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [15:0] adr;
      logic [7:0]  dat;
   } wbRequest;

   typedef struct packed {
      logic       ack;
      logic [7:0] dat;
   } wbResponse;

   typedef struct packed {
      logic [7:0] ly;
      ppuMode     mode;
      logic [8:0] dot;
      logic       coincidence;
   } lineStatus;

   typedef struct packed {
      logic [vramAddrWidth-1:0] addr;
      logic                     we;
      logic [7:0]               wdat;
   } vramPort;

   typedef struct packed {
      logic       valid;
      logic [1:0] shade;
      logic [7:0] line;
   } pixelOut;

endpackage

`default_nettype wire

//--- ppuTop.sv
`timescale 1ns/1ps
`default_nettype none

module ppuTop
   import ppuPkg::*;
#(
   parameter int unsigned linesVisible = 144,
   parameter int unsigned linesTotal   = 154
) (
   input  logic      clock,
   input  logic      rstN,
   input  wbRequest  wbReq,
   output wbResponse wbRsp,
   output logic      irq,
   output pixelOut   pixel
);

   lineStatus                status;
   vramPort                  cpuVram;
   logic [7:0]               cpuVramRdata;
   logic [7:0]               renderRdata;
   logic [vramAddrWidth-1:0] renderAddr;
   logic [2*screenWidth-1:0] indexLine;
   logic [7:0]               lyc;
   logic [7:0]               bgp;
   logic                     lcdEnable;
   logic                     lineReady;

   wbRegisterFile regFile_i (
      .clock        (clock),
      .rstN         (rstN),
      .wbReq        (wbReq),
      .status       (status),
      .cpuVramRdata (cpuVramRdata),
      .wbRsp        (wbRsp),
      .cpuVram      (cpuVram),
      .lcdEnable    (lcdEnable),
      .lyc          (lyc),
      .bgp          (bgp)
   );

   videoRam vram_i (
      .clock       (clock),
      .cpuPort     (cpuVram),
      .renderAddr  (renderAddr),
      .cpuRdata    (cpuVramRdata),
      .renderRdata (renderRdata)
   );

   lineTiming #(
      .linesVisible (linesVisible),
      .linesTotal   (linesTotal)
   ) timing_i (
      .clock     (clock),
      .rstN      (rstN),
      .lcdEnable (lcdEnable),
      .lyc       (lyc),
      .status    (status),
      .irq       (irq)
   );

   bgFetcher fetcher_i (
      .clock     (clock),
      .rstN      (rstN),
      .status    (status),
      .vramRdata (renderRdata),
      .vramAddr  (renderAddr),
      .indexLine (indexLine),
      .lineReady (lineReady)
   );

   pixelStreamer streamer_i (
      .clock     (clock),
      .rstN      (rstN),
      .status    (status),
      .bgp       (bgp),
      .indexLine (indexLine),
      .lineReady (lineReady),
      .pixel     (pixel)
   );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the PPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps --top-module tbPpu \
      -f filelist.f -o simPpu; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/simPpu > sim.log 2>&1
simStatus=$?
cat sim.log

if [ "$simStatus" -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

if grep -q "Test failures found" sim.log; then
   exit 1
fi
exit 0

//--- tbPpu.sv
`timescale 1ns/1ps
`default_nettype none

module tbPpu
   import ppuPkg::*;
();

   localparam int visibleLines = 4;
   localparam int totalLines   = 6;
   localparam int dotsPerLine  = 456;
   localparam int streamStart  = 253;    // Dot of pixel 0
   localparam int ackTimeout   = 16;

   logic      clock;
   logic      rstN;
   wbRequest  wbReq;
   wbResponse wbRsp;
   logic      irq;
   pixelOut   pixel;

   integer     seed;
   logic [7:0] mVram [0:8191];    // Reference VRAM
   logic [7:0] mLcdc;
   logic [7:0] mLyc;
   logic [7:0] mBgp;
   logic [3:0] mStatUp;
   int         mDot;
   int         mLy;
   logic       monitorOn;
   logic       pixelWanted;
   int         pixelsSeen;

   ppuTop #(
      .linesVisible (visibleLines),
      .linesTotal   (totalLines)
   ) dut_i (
      .clock (clock),
      .rstN  (rstN),
      .wbReq (wbReq),
      .wbRsp (wbRsp),
      .irq   (irq),
      .pixel (pixel)
   );

   initial begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   task automatic checkEqual(input int actual, input int expected, input string what);
      if (actual != expected) begin
         $display("FAILED at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
         $display("Test failures found");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   task automatic reportTimeout(input string what);
      $display("Timeout while waiting for %s", what);
      $display("Test failures found");
      $fatal(1, "Stopped on timeout");
   endtask

   function automatic int modeOf(int ly, int dot);
      if (!mLcdc[7])
         return 0;
      else if (ly >= visibleLines)
         return 1;
      else if (dot < 80)
         return 2;
      else if (dot < 252)
         return 3;
      return 0;
   endfunction

   function automatic logic [7:0] expectedRead(logic [15:0] adr, int mode, int ly);
      logic [7:0] value;
      if (adr[15:13] == 3'b100) begin
         value = (mode == 3) ? 8'hFF : mVram[adr[12:0]];    // Blocked in transfer
      end else begin
         case (adr)
            lcdcAddr: value = mLcdc;
            statAddr: value = {1'b0, mStatUp, ly == int'(mLyc), 2'(mode)};
            lyAddr:   value = 8'(ly);
            lycAddr:  value = mLyc;
            bgpAddr:  value = mBgp;
            default:  value = 8'hFF;
         endcase
      end
      return value;
   endfunction

   function automatic logic [1:0] expectedShade(int ly, int x);
      logic [7:0] tile;
      logic [7:0] lowPlane;
      logic [7:0] highPlane;
      logic [1:0] index;
      int         bitPos;
      tile      = mVram[13'(6144 + (ly / 8) * 32 + x / 8)];
      lowPlane  = mVram[13'(int'(tile) * 16 + (ly % 8) * 2)];
      highPlane = mVram[13'(int'(tile) * 16 + (ly % 8) * 2 + 1)];
      bitPos    = 7 - x % 8;    // Leftmost pixel in bit 7
      index     = {highPlane[bitPos], lowPlane[bitPos]};
      return mBgp[int'(index) * 2 +: 2];
   endfunction

   // Mode state at the negedge is what the DUT registers on the next edge
   task automatic busCycle(input logic we, input logic [15:0] adr, input logic [7:0] dat,
                           output logic [7:0] rdata, output int reqMode, output int reqLy);
      int count;
      @(negedge clock);
      wbReq   = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
      reqMode = modeOf(mLy, mDot);
      reqLy   = mLy;
      count   = 0;
      do begin
         @(negedge clock);
         count++;
      end while (!wbRsp.ack && count < ackTimeout);
      if (!wbRsp.ack)
         reportTimeout("Wishbone ack");
      rdata = wbRsp.dat;
      wbReq = '0;
   endtask

   task automatic busWrite(input logic [15:0] adr, input logic [7:0] dat);
      logic [7:0] ignored;
      int         reqMode;
      int         reqLy;
      busCycle(1'b1, adr, dat, ignored, reqMode, reqLy);
      if (adr[15:13] == 3'b100) begin
         if (reqMode != 3)
            mVram[adr[12:0]] = dat;
      end else begin
         case (adr)
            lcdcAddr: mLcdc   = dat;
            statAddr: mStatUp = dat[6:3];
            lycAddr:  mLyc    = dat;
            bgpAddr:  mBgp    = dat;
            default:  ;
         endcase
      end
   endtask

   task automatic readCheck(input logic [15:0] adr, output logic [7:0] data, output int reqLy);
      int reqMode;
      busCycle(1'b0, adr, 8'h00, data, reqMode, reqLy);
      checkEqual(int'(data), int'(expectedRead(adr, reqMode, reqLy)),
                 $sformatf("read of 0x%h", adr));
   endtask

   task automatic waitLine(input int target);
      int count;
      count = 0;
      while (mLy != target && count < 2 * totalLines * dotsPerLine) begin
         @(negedge clock);
         count++;
      end
      if (mLy != target)
         reportTimeout($sformatf("line %0d", target));
   endtask

   task automatic waitVisibleHBlank();
      int count;
      count = 0;
      while (!(modeOf(mLy, mDot) == 0 && mLy < visibleLines) && count < 2 * dotsPerLine) begin
         @(negedge clock);
         count++;
      end
      if (!(modeOf(mLy, mDot) == 0 && mLy < visibleLines))
         reportTimeout("horizontal blank");
   endtask

   always @(posedge clock) begin
      if (!mLcdc[7]) begin
         mDot <= 0;
         mLy  <= 0;
      end else if (mDot == dotsPerLine - 1) begin
         mDot <= 0;
         mLy  <= (mLy == totalLines - 1) ? 0 : mLy + 1;
      end else begin
         mDot <= mDot + 1;
      end
   end

   always @(negedge clock) begin
      if (monitorOn) begin
         checkEqual(32'(irq), (modeOf(mLy, mDot) == 1) ? 1 : 0, "irq level");
         pixelWanted = mLcdc[7] && mLy < visibleLines && mDot >= streamStart
                       && mDot < streamStart + 160;
         checkEqual(32'(pixel.valid), 32'(pixelWanted), "pixel valid");
         if (pixelWanted) begin
            checkEqual(32'(pixel.line), mLy, "pixel line");
            checkEqual(32'(pixel.shade), 32'(expectedShade(mLy, mDot - streamStart)),
                       $sformatf("shade of pixel %0d", mDot - streamStart));
            pixelsSeen++;
         end
      end
   end

   initial begin
      logic [7:0]  data;
      int          reqLy;
      int          prevLy;
      int          polls;
      logic [3:0]  seenVisible;
      logic [1:0]  seenBlank;
      logic        sawWrap;
      logic        sawCoin;
      seed = 32'h660b_f151;
      rstN = 1'b0;
      wbReq = '0;
      monitorOn = 1'b0;
      {mLcdc, mLyc, mBgp, mStatUp} = '0;
      pixelsSeen = 0;
      repeat (2) @(negedge clock);
      rstN = 1'b1;
      monitorOn = 1'b1;

      busWrite(lycAddr, 8'($random(seed)));
      busWrite(bgpAddr, 8'($random(seed)));
      busWrite(statAddr, 8'($random(seed)));
      readCheck(lycAddr, data, reqLy);
      readCheck(bgpAddr, data, reqLy);
      readCheck(statAddr, data, reqLy);
      readCheck(lyAddr, data, reqLy);
      readCheck(lcdcAddr, data, reqLy);
      readCheck(16'hFF42, data, reqLy);
      readCheck(16'hFF46, data, reqLy);
      readCheck(16'hA000, data, reqLy);
      for (int n = 0; n < 8; n++)
         readCheck({1'b0, 15'($random(seed))}, data, reqLy);    // Below VRAM window

      for (int c = 0; c < 32; c++)
         busWrite(16'(32'h9800 + c), 8'($random(seed)));    // Map row 0
      for (int t = 0; t < 256; t++)
         for (int r = 0; r < 8; r++)
            busWrite(16'(32'h8000 + t * 16 + r), 8'($random(seed)));
      for (int c = 0; c < 32; c++)
         readCheck(16'(32'h9800 + c), data, reqLy);
      for (int t = 0; t < 256; t++)
         for (int r = 0; r < 8; r++)
            readCheck(16'(32'h8000 + t * 16 + r), data, reqLy);

      busWrite(lcdcAddr, 8'h91);
      busWrite(lycAddr, 8'($unsigned($random(seed)) % 32'd6));
      seenVisible = '0;
      seenBlank = '0;
      sawWrap = 1'b0;
      sawCoin = 1'b0;
      prevLy = 0;
      for (int n = 0; n < 2000; n++) begin
         readCheck(lyAddr, data, reqLy);
         if (prevLy == totalLines - 1 && data == 8'd0)
            sawWrap = 1'b1;
         prevLy = int'(data);
         readCheck(statAddr, data, reqLy);
         if (reqLy < visibleLines)
            seenVisible[data[1:0]] = 1'b1;
         else if (data[1:0] == 2'd1)
            seenBlank[reqLy - visibleLines] = 1'b1;
         if (data[2])
            sawCoin = 1'b1;
      end
      checkEqual(32'(seenVisible), 32'hD, "modes seen on visible lines");
      checkEqual(32'(seenBlank), 32'h3, "vblank seen on lines 4 and 5");
      checkEqual(32'(sawWrap), 1, "LY wrap from 5 to 0");
      checkEqual(32'(sawCoin), 1, "coincidence flag seen");

      waitLine(visibleLines);
      busWrite(bgpAddr, 8'($random(seed)));
      pixelsSeen = 0;
      repeat (3) begin
         waitLine(0);
         waitLine(visibleLines);
         busWrite(bgpAddr, 8'($random(seed)));    // New palette in vblank
      end
      checkEqual(pixelsSeen, 3 * visibleLines * 160, "pixels streamed in three frames");

      polls = 0;
      data = 8'h00;
      while (data[1:0] != 2'd3 && polls < 2000) begin
         readCheck(statAddr, data, reqLy);
         polls++;
      end
      if (data[1:0] != 2'd3)
         reportTimeout("STAT mode 3");
      readCheck(16'h9819, data, reqLy);    // Map column 25 is never fetched
      busWrite(16'h9819, mVram[13'h1819] ^ 8'hA5);
      waitVisibleHBlank();
      readCheck(16'h9819, data, reqLy);

      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

//--- videoRam.sv
`timescale 1ns/1ps
`default_nettype none

module videoRam
   import ppuPkg::*;
(
   input  logic                     clock,
   input  vramPort                  cpuPort,
   input  logic [vramAddrWidth-1:0] renderAddr,
   output logic [7:0]               cpuRdata,
   output logic [7:0]               renderRdata
);

   logic [7:0] mem [0:(1 << vramAddrWidth) - 1];

   always_ff @(posedge clock) begin
      if (cpuPort.we)
         mem[cpuPort.addr] <= cpuPort.wdat;
      cpuRdata <= mem[cpuPort.addr];    // Old data on write
   end

   always_ff @(posedge clock) begin
      renderRdata <= mem[renderAddr];
   end

endmodule

`default_nettype wire

//--- wbRegisterFile.sv
`timescale 1ns/1ps
`default_nettype none

module wbRegisterFile
   import ppuPkg::*;
(
   input  logic       clock,
   input  logic       rstN,
   input  wbRequest   wbReq,
   input  lineStatus  status,
   input  logic [7:0] cpuVramRdata,
   output wbResponse  wbRsp,
   output vramPort    cpuVram,
   output logic       lcdEnable,
   output logic [7:0] lyc,
   output logic [7:0] bgp
);

   logic [7:0] lcdc;
   logic [3:0] statUpper;    // STAT bits 6..3
   logic       accept;
   logic       vramSel;
   logic       vramBlocked;
   logic [7:0] regData;
   logic       ackQ;
   logic       vramReadQ;
   logic       blockedQ;
   logic [7:0] regDataQ;

   assign accept      = wbReq.cyc && wbReq.stb && !ackQ;
   assign vramSel     = wbReq.adr[15:vramAddrWidth] == vramBusBase[15:vramAddrWidth];
   assign vramBlocked = status.mode == modeTransfer;

   assign cpuVram.addr = wbReq.adr[vramAddrWidth-1:0];
   assign cpuVram.we   = accept && wbReq.we && vramSel && !vramBlocked;
   assign cpuVram.wdat = wbReq.dat;

   always_comb begin
      case (wbReq.adr)
         lcdcAddr: regData = lcdc;
         statAddr: regData = {1'b0, statUpper, status.coincidence, status.mode};
         lyAddr:   regData = status.ly;
         lycAddr:  regData = lyc;
         bgpAddr:  regData = bgp;
         default:  regData = 8'hFF;    // Open bus
      endcase
   end

   always_ff @(posedge clock or negedge rstN) begin
      if (!rstN) begin
         ackQ      <= 1'b0;
         vramReadQ <= 1'b0;
         blockedQ  <= 1'b0;
         lcdc      <= 8'h00;
         statUpper <= 4'h0;
         lyc       <= 8'h00;
         bgp       <= 8'h00;
      end else begin
         ackQ <= accept;
         if (accept) begin
            vramReadQ <= vramSel;
            blockedQ  <= vramBlocked;
            if (wbReq.we) begin
               case (wbReq.adr)
                  lcdcAddr: lcdc      <= wbReq.dat;
                  statAddr: statUpper <= wbReq.dat[6:3];
                  lycAddr:  lyc       <= wbReq.dat;
                  bgpAddr:  bgp       <= wbReq.dat;
                  default:  ;
               endcase
            end
         end
      end
   end

   always_ff @(posedge clock) begin
      if (accept)
         regDataQ <= regData;
   end

   assign lcdEnable = lcdc[7];
   assign wbRsp.ack = ackQ;
   // RAM output already carries one clock of latency
   assign wbRsp.dat = vramReadQ ? (blockedQ ? 8'hFF : cpuVramRdata) : regDataQ;

endmodule

`default_nettype wire
